//--- dv/dna_port_model.sv
`timescale 1ns/1ps
`include "hk_defines.svh"

// behavioral stand-in for the device serial number port
module dna_port_model #(
  parameter hk_pkg::dna_t dna_value = '0
) (
  input  logic clk,
  input  logic read,
  input  logic shift,
  output logic dout
);

  import hk_pkg::*;

  dna_t sr;

  // content is unknown on the device until the first load
  initial begin
    sr = '0;
  end

  // read wins over shift, as on the device
  always @(posedge clk) begin
    if (read) begin
      sr <= dna_value;
    end else if (shift) begin
      // zeros enter from the bottom
      sr <= {sr[`HK_DNA_W-2:0], 1'b0};
    end
  end

  // msb is presented first
  assign dout = sr[`HK_DNA_W-1];

endmodule : dna_port_model

//--- dv/hk_tb.sv
`timescale 1ns/1ps
`include "hk_defines.svh"

module hk_tb;

  import hk_pkg::*;

  // serial number held by the port model
  localparam dna_t DNA_CONST = 57'h1_a5c3_f09e_174b_2d;
  // cycles allowed between request and ack
  localparam int ACK_WAIT  = 16;
  // status polls before the readout counts as stuck
  localparam int DNA_POLLS = 400;
  // EXP_IN polls before a pin pattern counts as lost
  localparam int PIN_POLLS = 16;

  logic     bus;
  logic     rst_n;
  sys_req_t req;
  sys_rsp_t rsp;
  logic     dna_clk;
  logic     dna_read;
  logic     dna_shift;
  logic     dna_dout;
  gpio_t    exp_in;
  gpio_t    exp_out;
  gpio_t    exp_oe;
  int       errors;

  //////////////////////////////////////////////////////////////////////
  // clock, DUT and port model
  //////////////////////////////////////////////////////////////////////

  initial begin
    bus = 1'b0;
  end

  // 8 ns period
  always #4 bus = ~bus;

  hk_top dut0 (
    .bus       (bus),
    .rst_n     (rst_n),
    .req       (req),
    .rsp       (rsp),
    .dna_clk   (dna_clk),
    .dna_read  (dna_read),
    .dna_shift (dna_shift),
    .dna_dout  (dna_dout),
    .exp_in    (exp_in),
    .exp_out   (exp_out),
    .exp_oe    (exp_oe)
  );

  dna_port_model #(
    .dna_value (DNA_CONST)
  ) dna0 (
    .clk   (dna_clk),
    .read  (dna_read),
    .shift (dna_shift),
    .dout  (dna_dout)
  );

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_data(input string name, input reg_data_t exp, input reg_data_t act);
    if (act !== exp) begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("Fail %s: expected err %b, actual err %b", name, exp, act);
    end
  endtask

  task automatic check_pins(input string name, input gpio_t exp, input gpio_t act);
    if (act !== exp) begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // single port pin level
  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("Fail %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // bus access
  //////////////////////////////////////////////////////////////////////

  // single strobe, then wait for ack
  task automatic bus_access(input logic write, input reg_addr_t addr, input reg_data_t wdata,
                            output reg_data_t rdata, output logic err);
    int n;
    @(posedge bus);
    #1;
    req.wen   = write;
    req.ren   = !write;
    req.addr  = addr;
    req.wdata = wdata;
    @(posedge bus);
    #1;
    req = '0;
    n   = 0;
    while (!rsp.ack && (n < ACK_WAIT)) begin
      @(posedge bus);
      #1;
      n++;
    end
    rdata = rsp.rdata;
    err   = rsp.err;
    if (rsp.ack !== 1'b1) begin
      errors++;
      $display("no ack from the DUT for the access to address %h", addr);
    end
  endtask

  task automatic bus_write(input reg_addr_t addr, input reg_data_t wdata,
                           output reg_data_t rdata, output logic err);
    bus_access(1'b1, addr, wdata, rdata, err);
  endtask

  task automatic bus_read(input reg_addr_t addr, output reg_data_t rdata, output logic err);
    bus_access(1'b0, addr, '0, rdata, err);
  endtask

  // refused access returns err and zero data
  task automatic expect_refused(input string name, input logic write, input reg_addr_t addr);
    reg_data_t rd;
    logic      err;
    bus_access(write, addr, 32'hffff_ffff, rd, err);
    check_err(name, 1'b1, err);
    check_data(name, '0, rd);
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_id();
    reg_data_t rd;
    logic      err;
    check_pins("reset_id: exp_oe", '0, exp_oe);
    check_pins("reset_id: exp_out", '0, exp_out);
    // port pins idle until the load period starts
    check_bit("reset_id: dna_clk", 1'b0, dna_clk);
    check_bit("reset_id: dna_read", 1'b0, dna_read);
    check_bit("reset_id: dna_shift", 1'b0, dna_shift);
    bus_read(`HK_REG_ID, rd, err);
    check_err("reset_id: ID read", 1'b0, err);
    check_data("reset_id: ID read", `HK_ID_VALUE, rd);
  endtask

  task automatic test_dna_readout();
    reg_data_t rd;
    logic      err;
    int        n;
    // value hidden while shifting
    bus_read(`HK_REG_DNA_LO, rd, err);
    check_data("dna_readout: DNA_LO before done", '0, rd);
    n = 0;
    do begin
      bus_read(`HK_REG_STATUS, rd, err);
      n++;
    end while ((rd[0] !== 1'b1) && (n < DNA_POLLS));
    if (rd[0] !== 1'b1) begin
      errors++;
      $display("DNA done flag never came up in STATUS");
    end
    check_data("dna_readout: STATUS", 32'h1, rd);
    // port left idle once finished
    check_bit("dna_readout: dna_clk after done", 1'b0, dna_clk);
    check_bit("dna_readout: dna_read after done", 1'b0, dna_read);
    check_bit("dna_readout: dna_shift after done", 1'b0, dna_shift);
    bus_read(`HK_REG_DNA_LO, rd, err);
    check_err("dna_readout: DNA_LO", 1'b0, err);
    check_data("dna_readout: DNA_LO", DNA_CONST[31:0], rd);
    // upper 25 bits, zero extended
    bus_read(`HK_REG_DNA_HI, rd, err);
    check_err("dna_readout: DNA_HI", 1'b0, err);
    check_data("dna_readout: DNA_HI", reg_data_t'(DNA_CONST >> 32), rd);
  endtask

  task automatic test_gpio_outputs();
    gpio_t     dir;
    gpio_t     out;
    reg_data_t rd;
    logic      err;
    int        i;
    for (i = 0; i < 4; i++) begin
      dir = gpio_t'($urandom);
      out = gpio_t'($urandom);
      bus_write(`HK_REG_EXP_DIR, reg_data_t'(dir), rd, err);
      check_err("gpio_outputs: EXP_DIR write", 1'b0, err);
      // bank register, then pad register
      @(posedge bus);
      #1;
      check_pins("gpio_outputs: exp_oe", dir, exp_oe);
      bus_write(`HK_REG_EXP_OUT, reg_data_t'(out), rd, err);
      check_err("gpio_outputs: EXP_OUT write", 1'b0, err);
      @(posedge bus);
      #1;
      check_pins("gpio_outputs: exp_out", out, exp_out);
      bus_read(`HK_REG_EXP_DIR, rd, err);
      check_data("gpio_outputs: EXP_DIR readback", reg_data_t'(dir), rd);
      bus_read(`HK_REG_EXP_OUT, rd, err);
      check_data("gpio_outputs: EXP_OUT readback", reg_data_t'(out), rd);
    end
  endtask

  task automatic test_input_change();
    gpio_t     prev;
    gpio_t     pat;
    gpio_t     diff;
    gpio_t     mask;
    reg_data_t rd;
    logic      err;
    int        n;
    int        i;
    prev = exp_in;
    for (i = 0; i < 4; i++) begin
      pat  = gpio_t'($urandom);
      mask = gpio_t'($urandom);
      // bits that toggled in either direction
      diff = prev ^ pat;
      @(posedge bus);
      #1;
      exp_in = pat;
      n = 0;
      do begin
        bus_read(`HK_REG_EXP_IN, rd, err);
        n++;
      end while ((rd !== reg_data_t'(pat)) && (n < PIN_POLLS));
      if (rd !== reg_data_t'(pat)) begin
        errors++;
        $display("EXP_IN never showed the pattern %h driven on exp_in", pat);
      end
      bus_read(`HK_REG_EXP_CHG, rd, err);
      check_data("input_change: EXP_CHG after edge", reg_data_t'(diff), rd);
      // write one to clear
      bus_write(`HK_REG_EXP_CHG, reg_data_t'(mask), rd, err);
      check_err("input_change: EXP_CHG write", 1'b0, err);
      bus_read(`HK_REG_EXP_CHG, rd, err);
      check_data("input_change: EXP_CHG after mask", reg_data_t'(diff & ~mask), rd);
      bus_write(`HK_REG_EXP_CHG, 32'hff, rd, err);
      bus_read(`HK_REG_EXP_CHG, rd, err);
      check_data("input_change: EXP_CHG cleared", '0, rd);
      prev = pat;
    end
  endtask

  task automatic test_bus_errors();
    reg_data_t rd;
    logic      err;
    bus_write(`HK_REG_EXP_DIR, 32'ha5, rd, err);
    check_err("bus_errors: EXP_DIR setup", 1'b0, err);
    // reads past the last register
    expect_refused("bus_errors: read 0x20", 1'b0, 32'h20);
    expect_refused("bus_errors: read 0x24", 1'b0, 32'h24);
    expect_refused("bus_errors: read 0x30", 1'b0, 32'h30);
    expect_refused("bus_errors: read 0x100", 1'b0, 32'h100);
    expect_refused("bus_errors: read 0x80000010", 1'b0, 32'h8000_0010);
    expect_refused("bus_errors: read 0xfffffffc", 1'b0, 32'hffff_fffc);
    // read only registers
    expect_refused("bus_errors: write ID", 1'b1, `HK_REG_ID);
    expect_refused("bus_errors: write DNA_LO", 1'b1, `HK_REG_DNA_LO);
    expect_refused("bus_errors: write DNA_HI", 1'b1, `HK_REG_DNA_HI);
    expect_refused("bus_errors: write STATUS", 1'b1, `HK_REG_STATUS);
    expect_refused("bus_errors: write EXP_IN", 1'b1, `HK_REG_EXP_IN);
    // low bits alias EXP_DIR
    expect_refused("bus_errors: write 0x30", 1'b1, 32'h30);
    bus_read(`HK_REG_EXP_DIR, rd, err);
    check_data("bus_errors: EXP_DIR unchanged", 32'ha5, rd);
    bus_read(`HK_REG_ID, rd, err);
    check_data("bus_errors: ID unchanged", `HK_ID_VALUE, rd);
  endtask

  //////////////////////////////////////////////////////////////////////
  // sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h61e6a886));
    errors = 0;
    rst_n  = 1'b0;
    req    = '0;
    exp_in = '0;
    // two cycles in reset
    repeat (2) @(posedge bus);
    #1;
    rst_n = 1'b1;
    test_reset_id();
    test_dna_readout();
    test_gpio_outputs();
    test_input_change();
    test_bus_errors();
    $display("hk_tb finished with %0d error(s)", errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule : hk_tb

//--- include/hk_defines.svh
`ifndef HK_DEFINES_SVH
`define HK_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// widths fixed by device and board
//////////////////////////////////////////////////////////////////////

// factory serial number length
`define HK_DNA_W    57
// expansion connector pins
`define HK_GPIO_W   8
// low address bits seen by the decoder
`define HK_ADDR_W   5

// design id, board type 1 in the low nibble, rest reserved
`define HK_ID_VALUE 32'h0000_0001

// bus cycles per dna clock period, even value
`define HK_DNA_DIV  8

//////////////////////////////////////////////////////////////////////
// register offsets, HK_ADDR_W bits wide
//////////////////////////////////////////////////////////////////////

`define HK_REG_ID      5'h00
`define HK_REG_DNA_LO  5'h04
`define HK_REG_DNA_HI  5'h08
`define HK_REG_STATUS  5'h0C
`define HK_REG_EXP_DIR 5'h10
`define HK_REG_EXP_OUT 5'h14
`define HK_REG_EXP_IN  5'h18
`define HK_REG_EXP_CHG 5'h1C

`endif

//--- list.f
+incdir+include
verilog/hk_pkg.sv
verilog/dna_reader.sv
verilog/exp_gpio.sv
verilog/hk_regs.sv
verilog/hk_top.sv
dv/dna_port_model.sv
dv/hk_tb.sv

//--- verilog/dna_reader.sv
`timescale 1ns/1ps
`include "hk_defines.svh"

module dna_reader (
  input  logic             bus,
  input  logic             rst_n,
  output logic             dna_clk,
  output logic             dna_read,
  output logic             dna_shift,
  input  logic             dna_dout,
  output hk_pkg::dna_sts_t sts
);

  import hk_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // divider and bit counter limits
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned DIV_W  = $clog2(`HK_DNA_DIV);
  localparam int unsigned BCNT_W = $clog2(`HK_DNA_W);

  // last cycle of a dna clock period
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`HK_DNA_DIV - 1);
  // dna_clk is high from here to the period end
  localparam logic [DIV_W-1:0] DIV_HALF = DIV_W'(`HK_DNA_DIV / 2);
  // cycle just before the rising edge
  localparam logic [DIV_W-1:0] DIV_SMPL = DIV_W'(`HK_DNA_DIV / 2 - 1);
  // index of the final sample
  localparam logic [BCNT_W-1:0] BIT_LAST = BCNT_W'(`HK_DNA_W - 1);

  dna_state_t        state;
  dna_state_t        state_nxt;
  logic [DIV_W-1:0]  div_cnt;
  logic [DIV_W-1:0]  div_nxt;
  logic [BCNT_W-1:0] bit_cnt;
  logic              period_end;
  logic              sample;
  logic              done;
  dna_t              shreg;

  //////////////////////////////////////////////////////////////////////
  // sequencing
  //////////////////////////////////////////////////////////////////////

  assign period_end = (div_cnt == DIV_LAST);
  // port output is stable here, the shift edge comes next cycle
  assign sample = (state == DNA_SHIFT) && (div_cnt == DIV_SMPL);

  always_comb begin
    state_nxt = state;
    case (state)
      // one full period with read high loads the port
      DNA_LOAD: begin
        if (period_end) begin
          state_nxt = DNA_SHIFT;
        end
      end
      // leave right after the last sample, no further clock edge
      DNA_SHIFT: begin
        if (sample && (bit_cnt == BIT_LAST)) begin
          state_nxt = DNA_DONE;
        end
      end
      // done is terminal, unused code too
      default: state_nxt = DNA_DONE;
    endcase
  end

  // divider parks at zero once finished
  assign div_nxt = ((state_nxt == DNA_DONE) || period_end) ? '0 : div_cnt + 1'b1;

  // pins follow the next state so they line up with state and div_cnt
  always_ff @(posedge bus) begin
    if (!rst_n) begin
      state     <= DNA_LOAD;
      div_cnt   <= '0;
      bit_cnt   <= '0;
      dna_clk   <= 1'b0;
      dna_read  <= 1'b0;
      dna_shift <= 1'b0;
    end else begin
      state     <= state_nxt;
      div_cnt   <= div_nxt;
      if (sample) begin
        bit_cnt <= bit_cnt + 1'b1;
      end
      dna_read  <= (state_nxt == DNA_LOAD);
      dna_shift <= (state_nxt == DNA_SHIFT);
      // second half of each period is high
      dna_clk   <= (state_nxt != DNA_DONE) && (div_nxt >= DIV_HALF);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // shift register, msb arrives first
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (sample) begin
      shreg <= {shreg[`HK_DNA_W-2:0], dna_dout};
    end
  end

  assign done      = (state == DNA_DONE);
  assign sts.done  = done;
  // hide partial shift contents
  assign sts.value = done ? shreg : '0;

  // readout happens once per reset
  a_done_sticky: assert property (@(posedge bus) disable iff (!rst_n) done |=> done)
    else $error("dna done flag dropped");

endmodule : dna_reader

//--- verilog/exp_gpio.sv
`timescale 1ns/1ps

module exp_gpio (
  input  logic              bus,
  input  logic              rst_n,
  input  hk_pkg::gpio_cfg_t cfg,
  input  hk_pkg::gpio_t     pad_in,
  output hk_pkg::gpio_t     pad_out,
  output hk_pkg::gpio_t     pad_oe,
  output hk_pkg::gpio_sts_t sts
);

  import hk_pkg::*;

  gpio_t      oe_q;
  gpio_t      out_q;
  gpio_t      sync1;
  gpio_t      sync2;
  gpio_t      prev;
  gpio_t      chg_q;
  gpio_t      chg_set;
  gpio_t      clr_mask;
  logic [2:0] settle;

  //////////////////////////////////////////////////////////////////////
  // output side
  //////////////////////////////////////////////////////////////////////

  // one register stage between bank and pads
  always_ff @(posedge bus) begin
    if (!rst_n) begin
      oe_q  <= '0;
      out_q <= '0;
    end else begin
      oe_q  <= cfg.dir;
      out_q <= cfg.out;
    end
  end

  assign pad_oe  = oe_q;
  assign pad_out = out_q;

  //////////////////////////////////////////////////////////////////////
  // input side
  //////////////////////////////////////////////////////////////////////

  // two flop synchronizer, prev holds last synchronized value
  always_ff @(posedge bus) begin
    if (!rst_n) begin
      sync1  <= '0;
      sync2  <= '0;
      prev   <= '0;
      settle <= '0;
    end else begin
      sync1  <= pad_in;
      sync2  <= sync1;
      prev   <= sync2;
      // fills with ones once the pipe holds real pin values
      settle <= {settle[1:0], 1'b1};
    end
  end

  // edges in either direction
  assign chg_set  = settle[2] ? (sync2 ^ prev) : '0;
  // clear only during the bank pulse
  assign clr_mask = cfg.chg_clr_en ? cfg.chg_clr : '0;

  // change latch
  // a new edge in the clear cycle survives
  always_ff @(posedge bus) begin
    if (!rst_n) begin
      chg_q <= '0;
    end else begin
      chg_q <= (chg_q & ~clr_mask) | chg_set;
    end
  end

  assign sts.pin_in = sync2;
  assign sts.chg    = chg_q;

  // bank sends single cycle clears
  a_clr_pulse: assert property (@(posedge bus) disable iff (!rst_n)
                                cfg.chg_clr_en |=> !cfg.chg_clr_en)
    else $error("change clear pulse longer than one cycle");

endmodule : exp_gpio

//--- verilog/hk_pkg.sv
`include "hk_defines.svh"

package hk_pkg;

  //////////////////////////////////////////////////////////////////////
  // vector types
  //////////////////////////////////////////////////////////////////////

  // bus words
  typedef logic [31:0]           reg_data_t;
  typedef logic [31:0]           reg_addr_t;
  // device serial number
  typedef logic [`HK_DNA_W-1:0]  dna_t;
  // one bit per connector pin
  typedef logic [`HK_GPIO_W-1:0] gpio_t;

  //////////////////////////////////////////////////////////////////////
  // system bus
  //////////////////////////////////////////////////////////////////////

  // request, one strobe per access
  typedef struct packed {
    logic      wen;
    logic      ren;
    reg_addr_t addr;
    reg_data_t wdata;
  } sys_req_t;

  // response, valid together with ack
  typedef struct packed {
    reg_data_t rdata;
    logic      ack;
    logic      err;
  } sys_rsp_t;

  //////////////////////////////////////////////////////////////////////
  // block interfaces
  //////////////////////////////////////////////////////////////////////

  // dna result, value is zero until done
  typedef struct packed {
    dna_t value;
    logic done;
  } dna_sts_t;

  // connector setup from the register bank
  typedef struct packed {
    gpio_t dir;
    gpio_t out;
    gpio_t chg_clr;
    logic  chg_clr_en;
  } gpio_cfg_t;

  // sampled connector state
  typedef struct packed {
    gpio_t pin_in;
    gpio_t chg;
  } gpio_sts_t;

  // dna readout sequence
  typedef enum logic [1:0] {
    DNA_LOAD,
    DNA_SHIFT,
    DNA_DONE
  } dna_state_t;

endpackage : hk_pkg

//--- verilog/hk_regs.sv
`timescale 1ns/1ps
`include "hk_defines.svh"

module hk_regs (
  input  logic              bus,
  input  logic              rst_n,
  input  hk_pkg::sys_req_t  req,
  output hk_pkg::sys_rsp_t  rsp,
  input  hk_pkg::dna_sts_t  dna,
  input  hk_pkg::gpio_sts_t gpio_sts,
  output hk_pkg::gpio_cfg_t gpio_cfg
);

  import hk_pkg::*;

  logic [`HK_ADDR_W-1:0] addr_lo;
  logic                  req_en;
  logic                  hit;
  logic                  ro;
  logic                  bad;
  logic                  wr_ok;
  reg_data_t             rd_mux;
  gpio_t                 dir_q;
  gpio_t                 out_q;
  gpio_t                 clr_mask_q;
  logic                  clr_en_q;
  logic                  ack_q;
  logic                  err_q;
  reg_data_t             rdata_q;

  //////////////////////////////////////////////////////////////////////
  // address decode and read mux
  //////////////////////////////////////////////////////////////////////

  assign addr_lo = req.addr[`HK_ADDR_W-1:0];
  assign req_en  = req.wen | req.ren;

  always_comb begin
    hit    = 1'b1;
    ro     = 1'b0;
    rd_mux = '0;
    case (addr_lo)
      `HK_REG_ID: begin
        ro     = 1'b1;
        rd_mux = `HK_ID_VALUE;
      end
      `HK_REG_DNA_LO: begin
        ro     = 1'b1;
        rd_mux = dna.value[31:0];
      end
      // upper 25 bits, zero extended
      `HK_REG_DNA_HI: begin
        ro     = 1'b1;
        rd_mux = reg_data_t'(dna.value[`HK_DNA_W-1:32]);
      end
      `HK_REG_STATUS: begin
        ro     = 1'b1;
        rd_mux = reg_data_t'(dna.done);
      end
      `HK_REG_EXP_DIR: rd_mux = reg_data_t'(dir_q);
      `HK_REG_EXP_OUT: rd_mux = reg_data_t'(out_q);
      `HK_REG_EXP_IN: begin
        ro     = 1'b1;
        rd_mux = reg_data_t'(gpio_sts.pin_in);
      end
      `HK_REG_EXP_CHG: rd_mux = reg_data_t'(gpio_sts.chg);
      // unaligned offsets
      default: hit = 1'b0;
    endcase
    // upper address bits must be clear
    if (req.addr > reg_addr_t'(`HK_REG_EXP_CHG)) begin
      hit = 1'b0;
    end
  end

  // miss, or write to a read only register
  assign bad   = req_en && (!hit || (req.wen && ro));
  assign wr_ok = req.wen && !bad;

  //////////////////////////////////////////////////////////////////////
  // writable registers and response
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (!rst_n) begin
      dir_q    <= '0;
      out_q    <= '0;
      clr_en_q <= 1'b0;
      ack_q    <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      // every request answered next cycle
      ack_q    <= req_en;
      err_q    <= bad;
      clr_en_q <= wr_ok && (addr_lo == `HK_REG_EXP_CHG);
      if (wr_ok && (addr_lo == `HK_REG_EXP_DIR)) begin
        dir_q <= req.wdata[`HK_GPIO_W-1:0];
      end
      if (wr_ok && (addr_lo == `HK_REG_EXP_OUT)) begin
        out_q <= req.wdata[`HK_GPIO_W-1:0];
      end
    end
  end

  // write one to clear mask, qualified by clr_en_q
  always_ff @(posedge bus) begin
    if (wr_ok && (addr_lo == `HK_REG_EXP_CHG)) begin
      clr_mask_q <= req.wdata[`HK_GPIO_W-1:0];
    end
  end

  // zero on writes and on errors
  always_ff @(posedge bus) begin
    rdata_q <= (req.ren && !bad) ? rd_mux : '0;
  end

  assign rsp.rdata = rdata_q;
  assign rsp.ack   = ack_q;
  assign rsp.err   = err_q;

  assign gpio_cfg.dir        = dir_q;
  assign gpio_cfg.out        = out_q;
  assign gpio_cfg.chg_clr    = clr_mask_q;
  assign gpio_cfg.chg_clr_en = clr_en_q;

  // master side of the handshake
  a_one_strobe: assert property (@(posedge bus) disable iff (!rst_n)
                                 !(req.wen && req.ren))
    else $error("write and read strobes together");

  a_wait_ack: assert property (@(posedge bus) disable iff (!rst_n) rsp.ack |-> !req_en)
    else $error("request issued while ack is out");

endmodule : hk_regs

//--- verilog/hk_top.sv
`timescale 1ns/1ps

module hk_top (
  input  logic             bus,
  input  logic             rst_n,
  // system bus
  input  hk_pkg::sys_req_t req,
  output hk_pkg::sys_rsp_t rsp,
  // dna port pins
  output logic             dna_clk,
  output logic             dna_read,
  output logic             dna_shift,
  input  logic             dna_dout,
  // expansion connector
  input  hk_pkg::gpio_t    exp_in,
  output hk_pkg::gpio_t    exp_out,
  output hk_pkg::gpio_t    exp_oe
);

  import hk_pkg::*;

  dna_sts_t  dna_sts;
  gpio_cfg_t gpio_cfg;
  gpio_sts_t gpio_sts;

  //////////////////////////////////////////////////////////////////////
  // readers and connector
  //////////////////////////////////////////////////////////////////////

  // one shot serial number readout after reset
  dna_reader u_dna (
    .bus       (bus),
    .rst_n     (rst_n),
    .dna_clk   (dna_clk),
    .dna_read  (dna_read),
    .dna_shift (dna_shift),
    .dna_dout  (dna_dout),
    .sts       (dna_sts)
  );

  // pad registers, sync and change latch
  exp_gpio u_gpio (
    .bus     (bus),
    .rst_n   (rst_n),
    .cfg     (gpio_cfg),
    .pad_in  (exp_in),
    .pad_out (exp_out),
    .pad_oe  (exp_oe),
    .sts     (gpio_sts)
  );

  //////////////////////////////////////////////////////////////////////
  // register bank
  //////////////////////////////////////////////////////////////////////

  hk_regs u_regs (
    .bus      (bus),
    .rst_n    (rst_n),
    .req      (req),
    .rsp      (rsp),
    .dna      (dna_sts),
    .gpio_sts (gpio_sts),
    .gpio_cfg (gpio_cfg)
  );

endmodule : hk_top
